// File: include/router_consts.svh
// Fixed sizes for the three-port router
// The header layout in the flit package depends on these values
// A change of DATA_W or COORD_W moves the reserved header field

`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// Flit width without the two preamble bits
`define ROUTER_DATA_W 32

// Width of one mesh coordinate
`define ROUTER_COORD_W 4

// Width of the message type in the header
`define ROUTER_MSG_W 4

// Entries in each input FIFO
`define ROUTER_FIFO_DEPTH 4

// East, West and Local
`define ROUTER_NPORTS 3

`endif

// File: design/router_link_pkg.sv
// Port indices, one-hot directions and coordinates
// Bit i of a direction request selects the port with index i

`include "router_consts.svh"

package router_link_pkg;

    typedef enum logic [1:0] {
        EAST  = 2'd0,
        WEST  = 2'd1,
        LOCAL = 2'd2
    } port_e;

    // One-hot request, bit 0 East, bit 1 West, bit 2 Local
    typedef logic [2:0] dir_t;

    localparam dir_t DIR_NONE  = 3'b000;
    localparam dir_t DIR_EAST  = 3'b001;
    localparam dir_t DIR_WEST  = 3'b010;
    localparam dir_t DIR_LOCAL = 3'b100;

    typedef logic [`ROUTER_COORD_W-1:0] coord_t;

    // Only x takes part in routing in this row of the mesh
    typedef struct packed {
        coord_t x;
        coord_t y;
    } xy_t;

endpackage

// File: design/router_flit_pkg.sv
// Flit formats carried on the router links
// The routing field is the lowest three bits of every flit
// It is only meaningful on a head flit

`include "router_consts.svh"

package router_flit_pkg;

    import router_link_pkg::*;

    // Whatever the header leaves over after coordinates, message and routing
    localparam int unsigned RSVD_W =
        `ROUTER_DATA_W - 2 * $bits(xy_t) - `ROUTER_MSG_W - $bits(dir_t);

    // Head and tail both set marks a one-flit worm
    typedef struct packed {
        logic head;
        logic tail;
    } preamble_t;

    typedef logic [`ROUTER_MSG_W-1:0] message_t;

    typedef struct packed {
        preamble_t            preamble;
        xy_t                  source;
        xy_t                  destination;
        message_t             message;
        logic [RSVD_W-1:0]    reserved;
        dir_t                 routing;
    } header_t;

    typedef logic [`ROUTER_DATA_W+$bits(preamble_t)-1:0] payload_t;

    // Head flits are decoded as header, body flits as raw data
    typedef union packed {
        header_t  header;
        payload_t raw;
    } flit_u;

    typedef struct packed {
        logic  valid;
        flit_u flit;
    } link_t;

endpackage

// File: design/router_input_port.sv
// Input side of one router port
// Upstream must not send while stop_o is high, nothing checks for overflow
// The pop strobes only act while the FIFO head is valid

`include "router_consts.svh"

module router_input_port
    import router_link_pkg::*;
    import router_flit_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  link_t                           link_i,
    input  xy_t                             position_i,
    input  logic [`ROUTER_NPORTS-1:0]       rd_i,
    output logic                            stop_o,
    output flit_u                           head_o,
    output logic                            head_valid_o,
    output dir_t                            request_o,
    output dir_t [`ROUTER_NPORTS-1:0]       next_route_o
);

    localparam int unsigned DEPTH = `ROUTER_FIFO_DEPTH;
    localparam int unsigned PTR_W = $clog2(DEPTH);
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam int unsigned XP_W  = `ROUTER_COORD_W + 1;

    flit_u            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             pop;
    logic             push_mem;
    logic             pop_mem;
    logic             valid_head;
    dir_t             held_req;
    logic [XP_W-1:0]  dst_p1;
    logic [XP_W-1:0]  pos_p1;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Both operands carry an offset of one so x-1 never wraps
    function automatic dir_t next_hop(input logic [XP_W-1:0] dst, input logic [XP_W-1:0] nb);
        dir_t d;
        if (dst > nb) begin
            d = DIR_EAST;
        end else if (dst < nb) begin
            d = DIR_WEST;
        end else begin
            d = DIR_LOCAL;
        end
        return d;
    endfunction

    ////////////////////////////////////////////////////////////
    // FIFO with bypass
    ////////////////////////////////////////////////////////////

    assign empty        = (count == '0);
    assign stop_o       = (count == CNT_W'(DEPTH));
    assign head_o       = empty ? link_i.flit : mem[rd_ptr];
    assign head_valid_o = empty ? link_i.valid : 1'b1;

    assign pop      = |rd_i & head_valid_o;
    // Flit goes straight through when it is read in its arrival cycle
    assign push_mem = link_i.valid & ~(empty & pop);
    assign pop_mem  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (push_mem) begin
            mem[wr_ptr] <= link_i.flit;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_mem) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop_mem) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push_mem, pop_mem})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Routing request and look-ahead
    ////////////////////////////////////////////////////////////

    assign valid_head = head_valid_o & head_o.header.preamble.head;
    assign request_o  = valid_head ? head_o.header.routing : held_req;

    // Body flits keep following the head's output until the tail leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            held_req <= DIR_NONE;
        end else if (pop) begin
            if (head_o.header.preamble.tail) begin
                held_req <= DIR_NONE;
            end else if (head_o.header.preamble.head) begin
                held_req <= head_o.header.routing;
            end
        end
    end

    assign dst_p1 = {1'b0, head_o.header.destination.x} + 1'b1;
    assign pos_p1 = {1'b0, position_i.x} + 1'b1;

    always_comb begin
        next_route_o[EAST]  = next_hop(dst_p1, pos_p1 + 1'b1);
        next_route_o[WEST]  = next_hop(dst_p1, pos_p1 - 1'b1);
        next_route_o[LOCAL] = DIR_LOCAL;
    end

endmodule

// File: design/router_arbiter.sv
// Round-robin arbiter between the two inputs that may feed one output
// The grant stays locked from head to tail of a worm

module router_arbiter (
    input  logic       clk,
    input  logic       rst,
    input  logic [1:0] request_i,
    input  logic       head_fwd_i,
    input  logic       tail_fwd_i,
    output logic [1:0] grant_o,
    output logic       grant_valid_o
);

    // Index of the input that wins a tie
    logic       prio;
    logic       locked;
    logic [1:0] held_grant;

    always_comb begin
        grant_o = '0;
        if (locked) begin
            grant_o = held_grant;
        end else if (request_i[prio]) begin
            grant_o[prio] = 1'b1;
        end else if (request_i[~prio]) begin
            grant_o[~prio] = 1'b1;
        end
    end

    assign grant_valid_o = |grant_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            prio       <= 1'b0;
            locked     <= 1'b0;
            held_grant <= '0;
        end else if (head_fwd_i) begin
            held_grant <= grant_o;
            // Priority moves past the winner
            prio       <= grant_o[0];
            // A one-flit worm never locks
            locked     <= ~tail_fwd_i;
        end else if (tail_fwd_i) begin
            locked <= 1'b0;
        end
    end

endmodule

// File: design/router_output_port.sv
// Output side of one router port with ACK/NACK flow control
// A worm never turns back, so the own input is never a candidate
// While stop_i is high nothing is read and link_o holds

`include "router_consts.svh"

module router_output_port
    import router_link_pkg::*;
    import router_flit_pkg::*;
#(
    parameter port_e SELF = EAST
) (
    input  logic                            clk,
    input  logic                            rst,
    input  flit_u [`ROUTER_NPORTS-1:0]      heads_i,
    input  logic [`ROUTER_NPORTS-1:0]       head_valid_i,
    input  dir_t [`ROUTER_NPORTS-1:0]       requests_i,
    input  dir_t [`ROUTER_NPORTS-1:0]       next_route_i,
    input  logic                            stop_i,
    output logic [`ROUTER_NPORTS-1:0]       rd_o,
    output link_t                           link_o
);

    // The two inputs that may target this output, lower index first
    localparam port_e CAND0 = (SELF == EAST) ? WEST : EAST;
    localparam port_e CAND1 = (SELF == LOCAL) ? WEST : LOCAL;

    typedef enum logic {
        WAIT_HEAD = 1'b0,
        FWD_BODY  = 1'b1
    } state_e;

    state_e     state;
    state_e     state_next;
    logic [1:0] cand_req;
    logic [1:0] grant;
    logic       grant_valid;
    port_e      sel_port;
    flit_u      sel_flit;
    flit_u      out_flit;
    logic       sel_valid;
    logic       fwd;
    logic       head_fwd;
    logic       tail_fwd;

    ////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////

    assign cand_req = {requests_i[CAND1][SELF], requests_i[CAND0][SELF]};

    router_arbiter u_arb (
        .clk           (clk),
        .rst           (rst),
        .request_i     (cand_req),
        .head_fwd_i    (head_fwd),
        .tail_fwd_i    (tail_fwd),
        .grant_o       (grant),
        .grant_valid_o (grant_valid)
    );

    ////////////////////////////////////////////////////////////
    // Switch and worm state
    ////////////////////////////////////////////////////////////

    assign sel_port  = grant[1] ? CAND1 : CAND0;
    assign sel_flit  = heads_i[sel_port];
    assign sel_valid = head_valid_i[sel_port];

    assign fwd      = grant_valid & sel_valid & ~stop_i;
    // In the waiting state the selected flit is always a head
    assign head_fwd = fwd & (state == WAIT_HEAD);
    assign tail_fwd = fwd & sel_flit.header.preamble.tail;

    always_comb begin
        rd_o           = '0;
        rd_o[sel_port] = fwd;
    end

    // Head carries the route the next router needs
    always_comb begin
        out_flit = sel_flit;
        if (state == WAIT_HEAD) begin
            out_flit.header.routing = next_route_i[sel_port];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            WAIT_HEAD: begin
                if (head_fwd && !tail_fwd) begin
                    state_next = FWD_BODY;
                end
            end
            FWD_BODY: begin
                if (tail_fwd) begin
                    state_next = WAIT_HEAD;
                end
            end
            default: state_next = WAIT_HEAD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WAIT_HEAD;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            link_o.valid <= 1'b0;
        end else if (!stop_i) begin
            link_o.valid <= fwd;
        end
    end

    always_ff @(posedge clk) begin
        if (!stop_i) begin
            link_o.flit <= out_flit;
        end
    end

endmodule

// File: design/lookahead_router.sv
// Three-port wormhole router for one row of the mesh
// Head flits arrive with the request for this router already set
// position_i is expected to stay constant after reset

`include "router_consts.svh"

module lookahead_router
    import router_link_pkg::*;
    import router_flit_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  xy_t                             position_i,
    input  link_t [`ROUTER_NPORTS-1:0]      in_link_i,
    output logic [`ROUTER_NPORTS-1:0]       stop_o,
    output link_t [`ROUTER_NPORTS-1:0]      out_link_o,
    input  logic [`ROUTER_NPORTS-1:0]       stop_i
);

    flit_u [`ROUTER_NPORTS-1:0]                         heads;
    logic [`ROUTER_NPORTS-1:0]                          head_valid;
    dir_t [`ROUTER_NPORTS-1:0]                          requests;
    // Indexed by input, then by exit
    dir_t [`ROUTER_NPORTS-1:0][`ROUTER_NPORTS-1:0]      next_route;
    // Indexed by output, then by input
    logic [`ROUTER_NPORTS-1:0][`ROUTER_NPORTS-1:0]      rd;

    for (genvar i = 0; i < `ROUTER_NPORTS; i++) begin : g_in
        router_input_port u_in (
            .clk          (clk),
            .rst          (rst),
            .link_i       (in_link_i[i]),
            .position_i   (position_i),
            .rd_i         ({rd[2][i], rd[1][i], rd[0][i]}),
            .stop_o       (stop_o[i]),
            .head_o       (heads[i]),
            .head_valid_o (head_valid[i]),
            .request_o    (requests[i]),
            .next_route_o (next_route[i])
        );
    end

    for (genvar o = 0; o < `ROUTER_NPORTS; o++) begin : g_out
        router_output_port #(
            .SELF (port_e'(o))
        ) u_out (
            .clk          (clk),
            .rst          (rst),
            .heads_i      (heads),
            .head_valid_i (head_valid),
            .requests_i   (requests),
            .next_route_i ({next_route[2][o], next_route[1][o], next_route[0][o]}),
            .stop_i       (stop_i[o]),
            .rd_o         (rd[o]),
            .link_o       (out_link_o[o])
        );
    end

endmodule

// File: testbench/router_chk.sv
// Assertions for one output port bound into every router_output_port
// state_i follows the output FSM encoding where 0 waits for a head flit

module router_chk
    import router_flit_pkg::*;
(
    input logic       clk,
    input logic       rst,
    input logic [1:0] req_i,
    input logic [1:0] grant_i,
    input logic       state_i,
    input logic       fwd_i,
    input logic       stop_i,
    input link_t      link_i
);
    timeunit 1ns;
    timeprecision 1ns;

    // A locked grant must still match the request held by its input
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant_i) && ((grant_i & ~req_i) == 2'b00))
        else $error("arbiter grant is not one-hot or goes to an input without a request");

    // A worm always starts with its head flit
    a_head_first: assert property (@(posedge clk) disable iff (rst)
        fwd_i && !state_i |=> link_i.valid && link_i.flit.header.preamble.head)
        else $error("flit forwarded in the waiting state is not a head flit");

    a_hold: assert property (@(posedge clk) disable iff (rst) stop_i |=> $stable(link_i))
        else $error("output link changed while stop_i was high");

endmodule

bind router_output_port router_chk u_chk (
    .clk     (clk),
    .rst     (rst),
    .req_i   (cand_req),
    .grant_i (grant),
    .state_i (state),
    .fwd_i   (fwd),
    .stop_i  (stop_i),
    .link_i  (link_o)
);

// File: testbench/router_tb.sv
// Directed tests for the router placed at x=5, y=2
// Worms to one output may arrive in either order but never interleaved

`include "router_consts.svh"

module router_tb
    import router_link_pkg::*;
    import router_flit_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ns;

    localparam int POS_X       = 5;
    localparam int TOTAL_FLITS = 3 + 3 + 8 + 8;
    localparam int LIMIT       = TOTAL_FLITS * 4 + 200;

    logic                       clk;
    logic                       rst;
    xy_t                        position;
    link_t [`ROUTER_NPORTS-1:0] in_link = '0;
    logic [`ROUTER_NPORTS-1:0]  stop_o;
    link_t [`ROUTER_NPORTS-1:0] out_link;
    logic [`ROUTER_NPORTS-1:0]  stop_i;
    logic [`ROUTER_NPORTS-1:0]  stop_q = '0;
    logic [31:0]                seed = 32'h437ce3e1;
    int                         cycles = 0;
    int                         cur_src [3] = '{0, 1, 2};
    flit_u                      tx_q [3][$];
    // Expected flits per input and output pair at index input * 3 + output
    flit_u                      exp_q [9][$];

    lookahead_router dut0 (
        .clk        (clk),
        .rst        (rst),
        .position_i (position),
        .in_link_i  (in_link),
        .stop_o     (stop_o),
        .out_link_o (out_link),
        .stop_i     (stop_i)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_link(input link_t got, input link_t exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_stop(input logic [2:0] got, input logic [2:0] exp, input string name);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Route the next router needs as seen from the neighbor behind exit out
    function automatic dir_t expect_route(input int dst_x, input port_e out);
        int nb;
        nb = (out == EAST) ? POS_X + 1 : POS_X - 1;
        if (out == LOCAL) return DIR_LOCAL;
        if (dst_x > nb) return DIR_EAST;
        if (dst_x < nb) return DIR_WEST;
        return DIR_LOCAL;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < 3; i++) n += tx_q[i].size();
        for (int i = 0; i < 9; i++) n += exp_q[i].size();
        return n;
    endfunction

    task automatic queue_worm(input port_e src, input int dst_x, input int len);
        flit_u f;
        flit_u e;
        port_e out;
        out = (dst_x > POS_X) ? EAST : (dst_x < POS_X) ? WEST : LOCAL;
        for (int k = 0; k < len; k++) begin
            seed  = next_random(seed);
            f.raw = {1'b0, (k == len - 1), seed};
            if (k == 0) begin
                f.header.preamble.head = 1'b1;
                f.header.source        = xy_t'{x: 4'(src), y: 4'd2};
                f.header.destination   = xy_t'{x: 4'(dst_x), y: 4'd2};
                f.header.routing       = dir_t'(1 << out);
            end
            e = f;
            if (k == 0) e.header.routing = expect_route(dst_x, out);
            tx_q[src].push_back(f);
            exp_q[src * 3 + out].push_back(e);
        end
    endtask

    task automatic wait_drained();
        while (pending() != 0) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Upstream senders and downstream model
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (tx_q[i].size() > 0 && !stop_o[i]) begin
                in_link[i].flit  = tx_q[i].pop_front();
                in_link[i].valid = 1'b1;
            end else begin
                in_link[i].valid = 1'b0;
            end
        end
    end

    // A head selects its worm by source and the body must follow from the same input
    task automatic match_arrival(input int o, input link_t got);
        link_t exp;
        int    src;
        int    q;
        if (got.flit.header.preamble.head) begin
            src = -1;
            for (int s = 0; s < 3; s++) begin
                q = s * 3 + o;
                if (exp_q[q].size() > 0 && exp_q[q][0].header.preamble.head
                        && exp_q[q][0].header.source === got.flit.header.source) begin
                    src = s;
                end
            end
            if (src < 0) fail_run($sformatf("output %0d sent a head flit no worm expects", o));
            cur_src[o] = src;
        end
        src = cur_src[o];
        if (exp_q[src * 3 + o].size() == 0) begin
            fail_run($sformatf("output %0d sent a flit while no flit was expected", o));
        end
        exp.valid = 1'b1;
        exp.flit  = exp_q[src * 3 + o].pop_front();
        check_link(got, exp, $sformatf("out_link_o[%0d]", o));
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int o = 0; o < 3; o++) begin
                if (out_link[o].valid && !stop_q[o]) match_arrival(o, out_link[o]);
            end
        end
    end

    always @(posedge clk) begin
        stop_q <= stop_i;
        cycles <= cycles + 1;
        if (cycles >= LIMIT) fail_run("timeout, the router stopped delivering the expected flits");
    end

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic after_reset();
        check_stop(stop_o, 3'b000, "stop_o");
        check_stop({out_link[2].valid, out_link[1].valid, out_link[0].valid}, 3'b000,
            "out_link_o valid");
    endtask

    // Head leaves one cycle after it is driven
    task automatic single_flit(input port_e src, input int dst_x, input port_e out);
        link_t exp;
        @(posedge clk);
        queue_worm(src, dst_x, 1);
        exp.valid = 1'b1;
        exp.flit  = exp_q[src * 3 + out][$];
        @(negedge clk);
        @(negedge clk);
        check_link(out_link[out], exp, $sformatf("out_link_o[%0d]", out));
        wait_drained();
    endtask

    task automatic worm_body();
        @(posedge clk);
        queue_worm(LOCAL, 1, 3);
        wait_drained();
    endtask

    task automatic two_worms();
        @(posedge clk);
        queue_worm(WEST, 8, 4);
        queue_worm(LOCAL, 6, 4);
        wait_drained();
    endtask

    task automatic back_pressure();
        link_t held;
        stop_i[EAST] = 1'b1;
        held = out_link[EAST];
        @(posedge clk);
        queue_worm(LOCAL, 9, 8);
        while (!stop_o[LOCAL]) @(negedge clk);
        repeat (2) @(negedge clk);
        check_stop(stop_o, 3'b100, "stop_o");
        check_link(out_link[EAST], held, "out_link_o[0]");
        if (tx_q[LOCAL].size() != 4) fail_run("stop_o did not rise after four accepted flits");
        stop_i[EAST] = 1'b0;
        wait_drained();
    endtask

    initial begin
        rst      = 1'b1;
        stop_i   = '0;
        position = xy_t'{x: 4'(POS_X), y: 4'd2};
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        after_reset();
        single_flit(LOCAL, 7, EAST);
        single_flit(LOCAL, 2, WEST);
        single_flit(EAST, 5, LOCAL);
        worm_body();
        two_worms();
        back_pressure();
        if (pending() != 0) begin
            fail_run("flits were still expected when the tests ended");
        end else begin
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+include
design/router_link_pkg.sv
design/router_flit_pkg.sv
design/router_input_port.sv
design/router_arbiter.sv
design/router_output_port.sv
design/lookahead_router.sv
testbench/router_chk.sv
testbench/router_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the router testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module router_tb -o router_sim

output="$(./obj_dir/router_sim 2>&1)" || true
echo "$output"

if echo "$output" | grep -qF "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
